/* dmem_subsys.f */
dmem_pkg.sv
dmem_router.sv
dmem_timer.sv
dmem_req_queue.sv
dmem_ahb_bridge.sv
dmem_subsys.sv
dmem_subsys_asserts.sv
dmem_subsys_tb.sv

/* Makefile */
TOP = dmem_subsys_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f dmem_subsys.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f dmem_subsys.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "FAIL: see sim.log"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log || (echo "FAIL: run ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* dmem_subsys_tb.sv */
//----------------------------------------
// Data memory subsystem testbench
// Directed tests with an AHB slave memory
//----------------------------------------
`timescale 1ns/1ps

module dmem_subsys_tb import dmem_pkg::*; ();

logic                   clk = 1'b0;
logic                   rst_n;
logic                   dmem_req;
dmem_req_t              dmem_req_pkt;
logic                   dmem_req_ack;
dmem_rsp_t              dmem_rsp;
logic                   timer_irq;
htrans_e                htrans;
logic [31:0]            haddr;
logic [2:0]             hsize;
logic                   hwrite;
logic [31:0]            hwdata;
logic                   hready = 1'b1;
logic [31:0]            hrdata = '0;
logic                   hresp = 1'b0;

int                     errors = 0;
int                     checks = 0;
integer                 seed = 32'h434c_de6a;
string                  cur_test = "reset";
dmem_rsp_t              rsp_q[$];       // Responses in arrival order
logic [2:0]             size_q[$];      // Expected hsize per AHB request
logic [31:0]            ahb_mem [256];

// Slave state
logic                   dphase = 1'b0;
int                     wait_left = 0;
int                     addr_wait = -1;     // Address phase stalls left, -1 before the draw
logic [31:0]            lat_addr;
logic                   lat_write;
logic [2:0]             lat_size;

always #4 clk = ~clk;

dmem_subsys uut (.*);

function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5A, idx + 8'hC3};
endfunction

function automatic logic [3:0] byte_en(input logic [2:0] size, input logic [1:0] lo);
    case (size)
        3'b000:  return 4'b0001 << lo;
        3'b001:  return lo[1] ? 4'b1100 : 4'b0011;
        default: return 4'b1111;
    endcase
endfunction

initial begin
    for (int i = 0; i < 256; i++) begin
        ahb_mem[i] = fill_word(i[7:0]);
    end
end

//----------------------------------------
// AHB slave memory model
//----------------------------------------
always @(negedge clk) begin
    logic [7:0] idx;
    logic [2:0] exp_size;
    logic [3:0] be;
    hresp  = 1'b0;
    hrdata = '0;
    if (dphase) begin
        if (wait_left > 0) begin
            hready    = 1'b0;
            wait_left = wait_left - 1;
        end else begin
            hready = 1'b1;
            dphase = 1'b0;
            idx    = lat_addr[9:2];
            be     = byte_en(lat_size, lat_addr[1:0]);
            if (lat_addr[31]) begin
                hresp = 1'b1;                   // Error region
            end else if (lat_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        ahb_mem[idx][8*b +: 8] = hwdata[8*b +: 8];
                    end
                end
            end else begin
                hrdata = ahb_mem[idx];
            end
        end
    end else begin
        hready = 1'b1;
        if (htrans == HTRANS_NONSEQ) begin
            // 0 to 3 wait states, split between address and data phase
            if (addr_wait < 0) begin
                wait_left = $unsigned($random(seed)) % 4;
                addr_wait = $unsigned($random(seed)) % (wait_left + 1);
                wait_left = wait_left - addr_wait;
            end
            if (addr_wait > 0) begin
                hready    = 1'b0;               // Stretch the address phase
                addr_wait = addr_wait - 1;
            end else begin
                addr_wait = -1;
                lat_addr  = haddr;
                lat_write = hwrite;
                lat_size  = hsize;
                dphase    = 1'b1;
                if (size_q.size() == 0) begin
                    errors++;
                    $display("AHB transfer to %08h with no request issued", haddr);
                end else begin
                    exp_size = size_q.pop_front();
                    checks++;
                    if (hsize !== exp_size) begin
                        errors++;
                        $display("MISMATCH %s hsize at %08h: expected %0d, actual %0d",
                                 cur_test, haddr, exp_size, hsize);
                    end
                end
            end
        end
    end
end

// Response monitor, stable after the falling edge
always @(negedge clk) begin
    #1;
    if (rst_n && dmem_rsp.resp != MEM_RESP_IDLE) begin
        rsp_q.push_back(dmem_rsp);
    end
end

//----------------------------------------
// Request helpers and checks
//----------------------------------------
function automatic dmem_req_t make_req(input mem_cmd_e cmd, input mem_width_e width,
                                       input logic [31:0] addr, input logic [31:0] wdata);
    dmem_req_t r;
    r.cmd   = cmd;
    r.width = width;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
endfunction

function automatic dmem_rsp_t ok_rsp(input logic [31:0] data);
    dmem_rsp_t r;
    r.resp  = MEM_RESP_RDY_OK;
    r.rdata = data;
    return r;
endfunction

function automatic dmem_rsp_t er_rsp();
    dmem_rsp_t r;
    r.resp  = MEM_RESP_RDY_ER;
    r.rdata = '0;
    return r;
endfunction

function automatic logic [31:0] timer_addr(input logic [4:0] offs);
    return {TIMER_ADDR_PATTERN[31:5], offs};
endfunction

// Called on a falling edge, returns on a falling edge
task automatic send_req(input dmem_req_t req);
    dmem_req     = 1'b1;
    dmem_req_pkt = req;
    if ((req.addr & TIMER_ADDR_MASK) != TIMER_ADDR_PATTERN) begin
        case (req.width)
            MEM_WIDTH_BYTE:  size_q.push_back(3'b000);
            MEM_WIDTH_HWORD: size_q.push_back(3'b001);
            default:         size_q.push_back(3'b010);
        endcase
    end
    #1;
    while (!dmem_req_ack) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    dmem_req = 1'b0;
endtask

task automatic get_rsp(output dmem_rsp_t rsp);
    do begin
        @(negedge clk);
    end while (rsp_q.size() == 0);
    rsp = rsp_q.pop_front();
endtask

task automatic check_rsp(input string name, input dmem_rsp_t exp, input dmem_rsp_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("MISMATCH %s: expected resp %0d rdata %08h, actual resp %0d rdata %08h",
                 name, exp.resp, exp.rdata, act.resp, act.rdata);
    end
endtask

task automatic check_irq(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("MISMATCH %s timer_irq: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic access(input mem_cmd_e cmd, input mem_width_e width, input logic [31:0] addr,
                      input logic [31:0] wdata, input dmem_rsp_t exp);
    dmem_rsp_t act;
    send_req(make_req(cmd, width, addr, wdata));
    get_rsp(act);
    check_rsp(cur_test, exp, act);
endtask

//----------------------------------------
// Directed tests
//----------------------------------------
task automatic test_timer_regs();
    cur_test = "timer_regs";
    access(MEM_CMD_WR, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_LO_OFFS), 32'h1234_5678,
           ok_rsp('0));
    access(MEM_CMD_WR, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_HI_OFFS), 32'h9ABC_DEF0,
           ok_rsp('0));
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_LO_OFFS), '0,
           ok_rsp(32'h1234_5678));
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_HI_OFFS), '0,
           ok_rsp(32'h9ABC_DEF0));
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_CTRL_OFFS), '0, ok_rsp('0));
endtask

task automatic test_timer_count();
    dmem_rsp_t   first;
    dmem_rsp_t   second;
    logic [31:0] delta;
    cur_test = "timer_count";
    // Stopped counter stays at zero
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIME_LO_OFFS), '0, ok_rsp('0));
    repeat (10) @(negedge clk);
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIME_LO_OFFS), '0, ok_rsp('0));
    access(MEM_CMD_WR, MEM_WIDTH_WORD, timer_addr(TIMER_CTRL_OFFS), 32'h1, ok_rsp('0));
    send_req(make_req(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIME_LO_OFFS), '0));
    get_rsp(first);
    repeat (20) @(negedge clk);
    send_req(make_req(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIME_LO_OFFS), '0));
    get_rsp(second);
    delta = second.rdata - first.rdata;
    checks++;
    if (first.resp !== MEM_RESP_RDY_OK || second.resp !== MEM_RESP_RDY_OK || delta < 20) begin
        errors++;
        $display("MISMATCH %s: expected delta >= 20 with ok, actual %0d (resp %0d %0d)",
                 cur_test, delta, first.resp, second.resp);
    end
endtask

task automatic test_timer_irq();
    cur_test = "timer_irq";
    access(MEM_CMD_WR, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_LO_OFFS), 32'h1, ok_rsp('0));
    access(MEM_CMD_WR, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_HI_OFFS), 32'h0, ok_rsp('0));
    repeat (3) @(negedge clk);
    check_irq(cur_test, 1'b1, timer_irq);
    access(MEM_CMD_WR, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_HI_OFFS), 32'hFFFF_FFFF,
           ok_rsp('0));
    repeat (3) @(negedge clk);
    check_irq(cur_test, 1'b0, timer_irq);
endtask

task automatic test_ahb_access();
    dmem_rsp_t   r0;
    dmem_rsp_t   r1;
    logic [31:0] exp_word;
    cur_test = "ahb_access";
    access(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_0100, 32'h1122_3344, ok_rsp('0));
    access(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0000_0101, 32'h0000_AB00, ok_rsp('0));
    access(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0000_0102, 32'hCDEF_0000, ok_rsp('0));
    access(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0100, '0, ok_rsp(32'hCDEF_AB44));
    check_rsp(cur_test, ok_rsp(32'hCDEF_AB44), ok_rsp(ahb_mem[8'h40]));  // Slave memory
    // Top byte over the fill pattern
    access(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0000_0107, 32'h5A00_0000, ok_rsp('0));
    exp_word        = fill_word(8'h41);
    exp_word[31:24] = 8'h5A;
    access(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0104, '0, ok_rsp(exp_word));
    send_req(make_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0200, '0));
    send_req(make_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0204, '0));
    get_rsp(r0);
    get_rsp(r1);
    check_rsp(cur_test, ok_rsp(fill_word(8'h80)), r0);
    check_rsp(cur_test, ok_rsp(fill_word(8'h81)), r1);
endtask

task automatic test_error_rsp();
    cur_test = "error_rsp";
    access(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h8000_0010, '0, er_rsp());
    access(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h8000_0020, 32'hDEAD_BEEF, er_rsp());
    access(MEM_CMD_RD, MEM_WIDTH_HWORD, timer_addr(TIMER_CTRL_OFFS), '0, er_rsp());
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(5'h04), '0, er_rsp());
    // Rejected halfword write leaves mtimecmp alone
    access(MEM_CMD_WR, MEM_WIDTH_HWORD, timer_addr(TIMER_MTIMECMP_LO_OFFS), 32'h7777, er_rsp());
    access(MEM_CMD_RD, MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_LO_OFFS), '0, ok_rsp(32'h1));
endtask

//----------------------------------------
// Main sequence and watchdog
//----------------------------------------
initial begin
    rst_n        = 1'b0;
    dmem_req     = 1'b0;
    dmem_req_pkt = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_irq(cur_test, 1'b0, timer_irq);
    test_timer_regs();
    test_timer_count();
    test_timer_irq();
    test_ahb_access();
    test_error_rsp();
    repeat (4) @(negedge clk);
    if (rsp_q.size() != 0) begin
        errors++;
        $display("%0d responses arrived with no request waiting", rsp_q.size());
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

// Reset, 5 tests at 200 cycles, 10 AHB accesses at 50 cycles
initial begin
    repeat (10 + 5 * 200 + 10 * 50) @(posedge clk);
    $display("Watchdog timeout while running %s", cur_test);
    $display("Simulation failed");
    $finish;
end

endmodule : dmem_subsys_tb

/* dmem_subsys_asserts.sv */
//----------------------------------------
// Data memory subsystem assertions
// AHB address hold, reset and IRQ checks
//----------------------------------------
`timescale 1ns/1ps

module dmem_subsys_asserts import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  htrans_e                 htrans,
    input  logic [DMEM_AWIDTH-1:0]  haddr,
    input  logic                    hwrite,
    input  logic                    hready,
    input  dmem_rsp_t               dmem_rsp,
    input  logic                    timer_irq
);

// Address phase must hold while the slave stalls
a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (htrans == HTRANS_NONSEQ && !hready) |=>
        (htrans == HTRANS_NONSEQ && $stable(haddr) && $stable(hwrite)))
    else $error("AHB address phase changed while hready was low");

a_rsp_reset: assert property (@(posedge clk)
    (!rst_n || $past(!rst_n)) |-> (dmem_rsp.resp == MEM_RESP_IDLE))
    else $error("Response not idle around reset");

a_irq_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(timer_irq))
    else $error("timer_irq is unknown");

endmodule : dmem_subsys_asserts

bind dmem_subsys dmem_subsys_asserts i_asserts (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .htrans    (htrans    ),
    .haddr     (haddr     ),
    .hwrite    (hwrite    ),
    .hready    (hready    ),
    .dmem_rsp  (dmem_rsp  ),
    .timer_irq (timer_irq )
);

/* dmem_subsys.sv */
//----------------------------------------
// Data memory subsystem top
// Router, timer, request queue, AHB master
//----------------------------------------
`timescale 1ns/1ps

module dmem_subsys import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // Core data port
    input  logic                    dmem_req,
    input  dmem_req_t               dmem_req_pkt,
    output logic                    dmem_req_ack,
    output dmem_rsp_t               dmem_rsp,
    output logic                    timer_irq,
    // AHB-Lite master
    output htrans_e                 htrans,
    output logic [DMEM_AWIDTH-1:0]  haddr,
    output logic [2:0]              hsize,
    output logic                    hwrite,
    output logic [DMEM_DWIDTH-1:0]  hwdata,
    input  logic                    hready,
    input  logic [DMEM_DWIDTH-1:0]  hrdata,
    input  logic                    hresp
);

logic       timer_sel;
dmem_req_t  timer_req;
dmem_rsp_t  timer_rsp;
logic       push;
dmem_req_t  push_req;
logic       full;
logic       pop;
logic       not_empty;
dmem_req_t  head_req;
dmem_rsp_t  ahb_rsp;

dmem_router i_router (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .dmem_req     (dmem_req     ),
    .dmem_req_pkt (dmem_req_pkt ),
    .dmem_req_ack (dmem_req_ack ),
    .dmem_rsp     (dmem_rsp     ),
    .timer_sel    (timer_sel    ),
    .timer_req    (timer_req    ),
    .timer_rsp    (timer_rsp    ),
    .push         (push         ),
    .push_req     (push_req     ),
    .full         (full         ),
    .ahb_rsp      (ahb_rsp      )
);

dmem_timer i_timer (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .timer_sel (timer_sel ),
    .timer_req (timer_req ),
    .timer_rsp (timer_rsp ),
    .timer_irq (timer_irq )
);

dmem_req_queue i_req_queue (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .push      (push      ),
    .push_req  (push_req  ),
    .full      (full      ),
    .pop       (pop       ),
    .not_empty (not_empty ),
    .head_req  (head_req  )
);

dmem_ahb_bridge i_ahb_bridge (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .not_empty (not_empty ),
    .head_req  (head_req  ),
    .pop       (pop       ),
    .ahb_rsp   (ahb_rsp   ),
    .htrans    (htrans    ),
    .haddr     (haddr     ),
    .hsize     (hsize     ),
    .hwrite    (hwrite    ),
    .hwdata    (hwdata    ),
    .hready    (hready    ),
    .hrdata    (hrdata    ),
    .hresp     (hresp     )
);

endmodule : dmem_subsys

/* dmem_ahb_bridge.sv */
//----------------------------------------
// AHB-Lite master bridge
// One transfer at a time from the queue head
//----------------------------------------
`timescale 1ns/1ps

module dmem_ahb_bridge import dmem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // Queue side
    input  logic                    not_empty,
    input  dmem_req_t               head_req,
    output logic                    pop,
    output dmem_rsp_t               ahb_rsp,
    // AHB-Lite
    output htrans_e                 htrans,
    output logic [DMEM_AWIDTH-1:0]  haddr,
    output logic [2:0]              hsize,
    output logic                    hwrite,
    output logic [DMEM_DWIDTH-1:0]  hwdata,
    input  logic                    hready,
    input  logic [DMEM_DWIDTH-1:0]  hrdata,
    input  logic                    hresp
);

ahb_state_e state;
dmem_req_t  cur_req;    // Transfer in progress

assign pop = (state == AHB_IDLE) && not_empty;

//----------------------------------------
// Transfer FSM
//----------------------------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        state <= AHB_IDLE;
    end else begin
        case (state)
            AHB_IDLE: if (not_empty) state <= AHB_ADDR;
            AHB_ADDR: if (hready)    state <= AHB_DATA;
            AHB_DATA: if (hready)    state <= AHB_IDLE;
            default:                 state <= AHB_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (pop) begin
        cur_req <= head_req;
    end
end

// Address phase held from the captured request
assign htrans = (state == AHB_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
assign haddr  = cur_req.addr;
assign hwrite = (state == AHB_ADDR) && (cur_req.cmd == MEM_CMD_WR);
assign hwdata = (state == AHB_DATA) ? cur_req.wdata : '0;

always_comb begin
    case (cur_req.width)
        MEM_WIDTH_BYTE:  hsize = 3'b000;
        MEM_WIDTH_HWORD: hsize = 3'b001;
        default:         hsize = 3'b010;    // Word
    endcase
end

//----------------------------------------
// Response at end of data phase
//----------------------------------------
always_comb begin
    ahb_rsp.resp  = MEM_RESP_IDLE;
    ahb_rsp.rdata = '0;
    if ((state == AHB_DATA) && hready) begin
        ahb_rsp.resp = hresp ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
        if (cur_req.cmd == MEM_CMD_RD) begin
            ahb_rsp.rdata = hrdata;
        end
    end
end

endmodule : dmem_ahb_bridge

/* dmem_req_queue.sv */
//----------------------------------------
// Request queue for AHB-bound requests
//----------------------------------------
`timescale 1ns/1ps

module dmem_req_queue import dmem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  dmem_req_t   push_req,
    output logic        full,
    input  logic        pop,
    output logic        not_empty,
    output dmem_req_t   head_req
);

dmem_req_t                              mem [REQ_QUEUE_DEPTH];
logic [$clog2(REQ_QUEUE_DEPTH)-1:0]     wr_ptr;
logic [$clog2(REQ_QUEUE_DEPTH)-1:0]     rd_ptr;
logic [$clog2(REQ_QUEUE_DEPTH+1)-1:0]   count;
logic                                   wr_en;
logic                                   rd_en;

assign full      = int'(count) == REQ_QUEUE_DEPTH;
assign not_empty = count != '0;
assign wr_en     = push && !full;
assign rd_en     = pop && not_empty;
assign head_req  = mem[rd_ptr];

always_ff @(posedge clk) begin
    if (wr_en) begin
        mem[wr_ptr] <= push_req;
    end
end

always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (wr_en) begin
            wr_ptr <= (int'(wr_ptr) == REQ_QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
        end
        if (rd_en) begin
            rd_ptr <= (int'(rd_ptr) == REQ_QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
        end
        case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
        endcase
    end
end

endmodule : dmem_req_queue

/* dmem_timer.sv */
//----------------------------------------
// Memory-mapped machine timer
// 64-bit mtime and mtimecmp, compare IRQ
//----------------------------------------
`timescale 1ns/1ps

module dmem_timer import dmem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        timer_sel,
    input  dmem_req_t   timer_req,
    output dmem_rsp_t   timer_rsp,
    output logic        timer_irq
);

logic                   enable;
logic [63:0]            mtime;
logic [63:0]            mtimecmp;
logic [4:0]             offs;
logic                   mapped;
logic                   req_ok;
logic                   wr_ok;
logic [DMEM_DWIDTH-1:0] rd_val;
dmem_rsp_t              rsp_r;

assign offs = timer_req.addr[4:0];

// Register read mux
always_comb begin
    mapped = 1'b1;
    case (offs)
        TIMER_CTRL_OFFS:        rd_val = {31'd0, enable};
        TIMER_MTIME_LO_OFFS:    rd_val = mtime[31:0];
        TIMER_MTIME_HI_OFFS:    rd_val = mtime[63:32];
        TIMER_MTIMECMP_LO_OFFS: rd_val = mtimecmp[31:0];
        TIMER_MTIMECMP_HI_OFFS: rd_val = mtimecmp[63:32];
        default: begin
            mapped = 1'b0;
            rd_val = '0;
        end
    endcase
end

// Word accesses to mapped offsets only
assign req_ok = timer_sel && mapped && (timer_req.width == MEM_WIDTH_WORD);
assign wr_ok  = req_ok && (timer_req.cmd == MEM_CMD_WR);

//----------------------------------------
// Registers and counter
//----------------------------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        enable   <= 1'b0;
        mtime    <= '0;
        mtimecmp <= '0;
    end else begin
        if (enable) begin
            mtime <= mtime + 64'd1;
        end
        // A written half overrides the increment
        if (wr_ok) begin
            case (offs)
                TIMER_CTRL_OFFS:        enable          <= timer_req.wdata[0];
                TIMER_MTIME_LO_OFFS:    mtime[31:0]     <= timer_req.wdata;
                TIMER_MTIME_HI_OFFS:    mtime[63:32]    <= timer_req.wdata;
                TIMER_MTIMECMP_LO_OFFS: mtimecmp[31:0]  <= timer_req.wdata;
                TIMER_MTIMECMP_HI_OFFS: mtimecmp[63:32] <= timer_req.wdata;
                default: ;
            endcase
        end
    end
end

// Response one cycle after select
always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        rsp_r     <= '0;
        timer_irq <= 1'b0;
    end else begin
        if (!timer_sel) begin
            rsp_r.resp <= MEM_RESP_IDLE;
        end else begin
            rsp_r.resp <= req_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        end
        rsp_r.rdata <= (req_ok && !wr_ok) ? rd_val : '0;
        timer_irq   <= enable && (mtime >= mtimecmp);   // Quiet while stopped
    end
end

assign timer_rsp = rsp_r;

endmodule : dmem_timer

/* dmem_router.sv */
//----------------------------------------
// Data memory router
// Steers core requests to timer or AHB and
// returns responses in request order
//----------------------------------------
`timescale 1ns/1ps

module dmem_router import dmem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Core side
    input  logic        dmem_req,
    input  dmem_req_t   dmem_req_pkt,
    output logic        dmem_req_ack,
    output dmem_rsp_t   dmem_rsp,
    // Timer port
    output logic        timer_sel,
    output dmem_req_t   timer_req,
    input  dmem_rsp_t   timer_rsp,
    // AHB port through the queue
    output logic        push,
    output dmem_req_t   push_req,
    input  logic        full,
    input  dmem_rsp_t   ahb_rsp
);

logic       hit_timer;
logic       owner_timer;    // Port of outstanding requests
logic [1:0] out_cnt;
logic       port_free;
logic       timer_pend;
logic       rsp_done;

assign hit_timer  = (dmem_req_pkt.addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN;
assign port_free  = (out_cnt == 2'd0) || (owner_timer == hit_timer);
assign timer_pend = owner_timer && (out_cnt != 2'd0);

//----------------------------------------
// Acceptance
//----------------------------------------
always_comb begin
    if (!port_free) begin
        dmem_req_ack = 1'b0;        // Other port still busy
    end else if (hit_timer) begin
        dmem_req_ack = dmem_req && !timer_pend;
    end else begin
        dmem_req_ack = dmem_req && !full && (out_cnt < 2'd2);
    end
end

assign timer_sel = dmem_req_ack && hit_timer;
assign timer_req = dmem_req_pkt;
assign push      = dmem_req_ack && !hit_timer;
assign push_req  = dmem_req_pkt;

// Only the owning port can answer
assign dmem_rsp = owner_timer ? timer_rsp : ahb_rsp;
assign rsp_done = dmem_rsp.resp != MEM_RESP_IDLE;

always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        owner_timer <= 1'b0;
        out_cnt     <= 2'd0;
    end else begin
        if (dmem_req_ack) begin
            owner_timer <= hit_timer;
        end
        case ({dmem_req_ack, rsp_done})
            2'b10:   out_cnt <= out_cnt + 2'd1;
            2'b01:   out_cnt <= out_cnt - 2'd1;
            default: ;                          // Hold on both or neither
        endcase
    end
end

endmodule : dmem_router

/* dmem_pkg.sv */
//----------------------------------------
// Data memory subsystem definitions
// Request and response types, AHB encodings
// and the timer address map
//----------------------------------------

package dmem_pkg;

// Bus widths
localparam int DMEM_AWIDTH = 32;
localparam int DMEM_DWIDTH = 32;

//----------------------------------------
// Core-side memory interface
//----------------------------------------
typedef enum logic {
    MEM_CMD_RD = 1'b0,
    MEM_CMD_WR = 1'b1
} mem_cmd_e;

typedef enum logic [1:0] {
    MEM_WIDTH_BYTE  = 2'b00,
    MEM_WIDTH_HWORD = 2'b01,
    MEM_WIDTH_WORD  = 2'b10
} mem_width_e;

typedef enum logic [1:0] {
    MEM_RESP_IDLE   = 2'b00,    // No response this cycle
    MEM_RESP_RDY_OK = 2'b01,
    MEM_RESP_RDY_ER = 2'b10
} mem_resp_e;

typedef struct packed {
    mem_cmd_e                   cmd;
    mem_width_e                 width;
    logic [DMEM_AWIDTH-1:0]     addr;
    logic [DMEM_DWIDTH-1:0]     wdata;
} dmem_req_t;

typedef struct packed {
    mem_resp_e                  resp;
    logic [DMEM_DWIDTH-1:0]     rdata;
} dmem_rsp_t;

//----------------------------------------
// AHB-Lite encodings
//----------------------------------------
typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10
} htrans_e;

typedef enum logic [1:0] {
    AHB_IDLE = 2'b00,
    AHB_ADDR = 2'b01,
    AHB_DATA = 2'b10
} ahb_state_e;

// Timer window, 32 bytes
localparam logic [31:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0;
localparam logic [31:0] TIMER_ADDR_PATTERN = 32'h0049_0000;

// Timer register offsets
localparam logic [4:0] TIMER_CTRL_OFFS        = 5'h00;
localparam logic [4:0] TIMER_MTIME_LO_OFFS    = 5'h08;
localparam logic [4:0] TIMER_MTIME_HI_OFFS    = 5'h0C;
localparam logic [4:0] TIMER_MTIMECMP_LO_OFFS = 5'h10;
localparam logic [4:0] TIMER_MTIMECMP_HI_OFFS = 5'h14;

localparam int REQ_QUEUE_DEPTH = 2;     // AHB requests in flight

endpackage : dmem_pkg
